//--- src/qosmem_pkg.sv
// Sizes are fixed here; NUM_PORTS and NUM_LEVELS must stay 4 to match the 2-bit IDs
package qosmem_pkg;

    // ------------------------------------------------------------------------
    // Sizes
    // ------------------------------------------------------------------------
    localparam int NUM_PORTS       = 4;
    localparam int NUM_LEVELS      = 4;
    localparam int QUEUE_DEPTH     = 4;
    localparam int MAX_OUTSTANDING = 8;
    localparam int ADDR_W          = 32;
    localparam int DATA_W          = 32;
    // Statistics counters wrap at this width
    localparam int COUNT_W         = 16;

    // ------------------------------------------------------------------------
    // Types
    // ------------------------------------------------------------------------
    typedef logic [1:0] port_id_t;

    // Higher value wins
    typedef logic [1:0] level_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              we;
        logic [DATA_W-1:0] wdata;
    } mem_req_t;

    // Request tagged with the port it came from
    typedef struct packed {
        mem_req_t req;
        port_id_t port;
    } queue_entry_t;

endpackage

//--- src/qos_level_if.sv
// Push is at most one per level per cycle; pop has at most one bit set
`timescale 1ns/10ps

interface qos_level_if;

    // Scheduler side
    logic [qosmem_pkg::NUM_LEVELS-1:0]                          push;
    qosmem_pkg::port_id_t [qosmem_pkg::NUM_LEVELS-1:0]          push_port;
    logic [qosmem_pkg::NUM_LEVELS-1:0]                          pop;

    // Queue bank side
    logic [qosmem_pkg::NUM_LEVELS-1:0]                          full;
    logic [qosmem_pkg::NUM_LEVELS-1:0]                          empty;
    qosmem_pkg::queue_entry_t [qosmem_pkg::NUM_LEVELS-1:0]      head;

    modport sched (
        output push,
        output push_port,
        output pop,
        input  full,
        input  empty,
        input  head
    );

    modport bank (
        input  push,
        input  push_port,
        input  pop,
        output full,
        output empty,
        output head
    );

endinterface

//--- src/qos_fifo.sv
// DEPTH must be a power of two and at least 2; push when full or pop when empty is dropped
`timescale 1ns/10ps

module qos_fifo #(
    parameter int  DEPTH     = 4,
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     push_i,
    input  payload_t push_data_i,
    input  logic     pop_i,
    output payload_t head_o,
    output logic     full_o,
    output logic     empty_o
);

    payload_t               mem_q [DEPTH];
    logic [$clog2(DEPTH)-1:0] wr_ptr_q;
    logic [$clog2(DEPTH)-1:0] rd_ptr_q;
    logic [$clog2(DEPTH):0]   count_q;
    logic                   do_push;
    logic                   do_pop;

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    assign full_o  = (count_q == DEPTH[$clog2(DEPTH):0]);
    assign empty_o = (count_q == '0);

    // Head is visible in the same cycle
    assign head_o = mem_q[rd_ptr_q];

    // Pointers wrap naturally since DEPTH is a power of two
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

endmodule

//--- src/qos_level_bank.sv
// One queue per QoS level; the scheduler guarantees at most one push per level per cycle
`timescale 1ns/10ps

module qos_level_bank (
    input  logic                                           clk_i,
    input  logic                                           rst_ni,
    input  qosmem_pkg::mem_req_t [qosmem_pkg::NUM_PORTS-1:0] port_req_i,
    qos_level_if.bank                                      lvl
);

    qosmem_pkg::queue_entry_t [qosmem_pkg::NUM_LEVELS-1:0] push_entry;

    for (genvar l = 0; l < qosmem_pkg::NUM_LEVELS; l++) begin : g_level

        // Pick the winning port's request and tag it with its ID
        assign push_entry[l].req  = port_req_i[lvl.push_port[l]];
        assign push_entry[l].port = lvl.push_port[l];

        qos_fifo #(
            .DEPTH     (qosmem_pkg::QUEUE_DEPTH),
            .payload_t (qosmem_pkg::queue_entry_t)
        ) level_fifo_inst (
            .clk_i       (clk_i),
            .rst_ni      (rst_ni),
            .push_i      (lvl.push[l]),
            .push_data_i (push_entry[l]),
            .pop_i       (lvl.pop[l]),
            .head_o      (lvl.head[l]),
            .full_o      (lvl.full[l]),
            .empty_o     (lvl.empty[l])
        );

    end

endmodule

//--- src/qos_scheduler.sv
// Purely combinational; strict priority can starve lower levels under sustained load
`timescale 1ns/10ps

module qos_scheduler (
    input  logic [qosmem_pkg::NUM_PORTS-1:0]                  req_valid_i,
    input  qosmem_pkg::level_t [qosmem_pkg::NUM_PORTS-1:0]    port_level_i,
    output logic [qosmem_pkg::NUM_PORTS-1:0]                  req_ready_o,
    input  logic                                              mem_req_ready_i,
    output logic                                              mem_req_valid_o,
    output qosmem_pkg::mem_req_t                              mem_req_o,
    input  logic                                              track_full_i,
    output logic                                              issue_o,
    output qosmem_pkg::port_id_t                              issue_port_o,
    qos_level_if.sched                                        lvl
);

    logic               sel_valid;
    qosmem_pkg::level_t sel_lvl;

    // ------------------------------------------------------------------------
    // Intake: lowest port index wins each level
    // ------------------------------------------------------------------------
    always_comb begin
        logic blocked;
        for (int p = 0; p < qosmem_pkg::NUM_PORTS; p++) begin
            blocked = 1'b0;
            for (int q = 0; q < p; q++) begin
                if (req_valid_i[q] && port_level_i[q] == port_level_i[p]) begin
                    blocked = 1'b1;
                end
            end
            // Ready does not look at the port's own valid
            req_ready_o[p] = !lvl.full[port_level_i[p]] && !blocked;
        end
    end

    always_comb begin
        lvl.push      = '0;
        lvl.push_port = '0;
        for (int p = 0; p < qosmem_pkg::NUM_PORTS; p++) begin
            if (req_valid_i[p] && req_ready_o[p]) begin
                lvl.push[port_level_i[p]]      = 1'b1;
                lvl.push_port[port_level_i[p]] = qosmem_pkg::port_id_t'(p);
            end
        end
    end

    // ------------------------------------------------------------------------
    // Issue: highest non-empty level goes to memory
    // ------------------------------------------------------------------------
    always_comb begin
        sel_valid = 1'b0;
        sel_lvl   = '0;
        for (int l = qosmem_pkg::NUM_LEVELS - 1; l >= 0; l--) begin
            if (!lvl.empty[l] && !sel_valid) begin
                sel_valid = 1'b1;
                sel_lvl   = qosmem_pkg::level_t'(l);
            end
        end
    end

    // Held off while the response tracker has no room
    assign mem_req_valid_o = sel_valid && !track_full_i;
    assign mem_req_o       = lvl.head[sel_lvl].req;

    assign issue_o      = mem_req_valid_o && mem_req_ready_i;
    assign issue_port_o = lvl.head[sel_lvl].port;

    always_comb begin
        lvl.pop = '0;
        if (issue_o) begin
            lvl.pop[sel_lvl] = 1'b1;
        end
    end

endmodule

//--- src/qos_rsp_router.sv
// Assumes in-order memory responses; a response with nothing outstanding is dropped
`timescale 1ns/10ps

module qos_rsp_router (
    input  logic                                                  clk_i,
    input  logic                                                  rst_ni,
    input  logic                                                  issue_i,
    input  qosmem_pkg::port_id_t                                  issue_port_i,
    output logic                                                  track_full_o,
    input  logic                                                  mem_rsp_valid_i,
    input  logic [qosmem_pkg::DATA_W-1:0]                         mem_rsp_rdata_i,
    output logic [qosmem_pkg::NUM_PORTS-1:0]                      rsp_valid_o,
    output logic [qosmem_pkg::NUM_PORTS-1:0][qosmem_pkg::DATA_W-1:0] rsp_rdata_o,
    output logic                                                  rsp_done_o,
    output qosmem_pkg::port_id_t                                  rsp_port_o
);

    qosmem_pkg::port_id_t oldest_port;
    logic                 track_empty;
    logic                 rsp_fire;

    // Source ports of issued requests, oldest at the head
    qos_fifo #(
        .DEPTH     (qosmem_pkg::MAX_OUTSTANDING),
        .payload_t (qosmem_pkg::port_id_t)
    ) track_fifo_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .push_i      (issue_i),
        .push_data_i (issue_port_i),
        .pop_i       (rsp_fire),
        .head_o      (oldest_port),
        .full_o      (track_full_o),
        .empty_o     (track_empty)
    );

    assign rsp_fire = mem_rsp_valid_i && !track_empty;

    // One-cycle strobe on the owning port
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rsp_valid_o <= '0;
            rsp_port_o  <= '0;
        end else begin
            rsp_valid_o <= '0;
            if (rsp_fire) begin
                rsp_valid_o[oldest_port] <= 1'b1;
                rsp_port_o               <= oldest_port;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rsp_fire) begin
            rsp_rdata_o[oldest_port] <= mem_rsp_rdata_i;
        end
    end

    assign rsp_done_o = |rsp_valid_o;

endmodule

//--- src/qos_port_stats.sv
// Counters wrap at COUNT_W bits and are not saturated
`timescale 1ns/10ps

module qos_port_stats (
    input  logic                                                   clk_i,
    input  logic                                                   rst_ni,
    input  logic                                                   issue_i,
    input  qosmem_pkg::port_id_t                                   issue_port_i,
    input  logic                                                   rsp_done_i,
    input  qosmem_pkg::port_id_t                                   rsp_port_i,
    output logic [qosmem_pkg::NUM_PORTS-1:0][qosmem_pkg::COUNT_W-1:0] issued_cnt_o,
    output logic [qosmem_pkg::NUM_PORTS-1:0][qosmem_pkg::COUNT_W-1:0] done_cnt_o
);

    for (genvar p = 0; p < qosmem_pkg::NUM_PORTS; p++) begin : g_port

        always_ff @(posedge clk_i or negedge rst_ni) begin
            if (!rst_ni) begin
                issued_cnt_o[p] <= '0;
                done_cnt_o[p]   <= '0;
            end else begin
                // Requests accepted by memory
                if (issue_i && issue_port_i == qosmem_pkg::port_id_t'(p)) begin
                    issued_cnt_o[p] <= issued_cnt_o[p] + 1'b1;
                end
                // Responses handed back to the port
                if (rsp_done_i && rsp_port_i == qosmem_pkg::port_id_t'(p)) begin
                    done_cnt_o[p] <= done_cnt_o[p] + 1'b1;
                end
            end
        end

    end

endmodule

//--- src/qosmem_top.sv
// Memory must answer in issue order with no back-pressure on mem_rsp_valid_i
`timescale 1ns/10ps

module qosmem_top (
    input  logic                                                   clk_i,
    input  logic                                                   rst_ni,

    // Requester ports
    input  logic [qosmem_pkg::NUM_PORTS-1:0]                       req_valid_i,
    input  logic [qosmem_pkg::NUM_PORTS-1:0][qosmem_pkg::ADDR_W-1:0] req_addr_i,
    input  logic [qosmem_pkg::NUM_PORTS-1:0]                       req_we_i,
    input  logic [qosmem_pkg::NUM_PORTS-1:0][qosmem_pkg::DATA_W-1:0] req_wdata_i,
    input  qosmem_pkg::level_t [qosmem_pkg::NUM_PORTS-1:0]         port_level_i,
    output logic [qosmem_pkg::NUM_PORTS-1:0]                       req_ready_o,
    output logic [qosmem_pkg::NUM_PORTS-1:0]                       rsp_valid_o,
    output logic [qosmem_pkg::NUM_PORTS-1:0][qosmem_pkg::DATA_W-1:0] rsp_rdata_o,

    // Memory side
    output logic                                                   mem_req_valid_o,
    input  logic                                                   mem_req_ready_i,
    output logic [qosmem_pkg::ADDR_W-1:0]                          mem_req_addr_o,
    output logic                                                   mem_req_we_o,
    output logic [qosmem_pkg::DATA_W-1:0]                          mem_req_wdata_o,
    input  logic                                                   mem_rsp_valid_i,
    input  logic [qosmem_pkg::DATA_W-1:0]                          mem_rsp_rdata_i,

    // Statistics
    output logic [qosmem_pkg::NUM_PORTS-1:0][qosmem_pkg::COUNT_W-1:0] issued_cnt_o,
    output logic [qosmem_pkg::NUM_PORTS-1:0][qosmem_pkg::COUNT_W-1:0] done_cnt_o
);

    qosmem_pkg::mem_req_t [qosmem_pkg::NUM_PORTS-1:0] port_req;
    qosmem_pkg::mem_req_t                             mem_req;
    logic                                             issue;
    qosmem_pkg::port_id_t                             issue_port;
    logic                                             track_full;
    logic                                             rsp_done;
    qosmem_pkg::port_id_t                             rsp_port;

    // ------------------------------------------------------------------------
    // Request packing
    // ------------------------------------------------------------------------
    for (genvar p = 0; p < qosmem_pkg::NUM_PORTS; p++) begin : g_pack
        assign port_req[p].addr  = req_addr_i[p];
        assign port_req[p].we    = req_we_i[p];
        assign port_req[p].wdata = req_wdata_i[p];
    end

    assign mem_req_addr_o  = mem_req.addr;
    assign mem_req_we_o    = mem_req.we;
    assign mem_req_wdata_o = mem_req.wdata;

    // ------------------------------------------------------------------------
    // Instances
    // ------------------------------------------------------------------------
    qos_level_if lvl_if_inst ();

    qos_scheduler qos_scheduler_inst (
        .req_valid_i     (req_valid_i),
        .port_level_i    (port_level_i),
        .req_ready_o     (req_ready_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_o       (mem_req),
        .track_full_i    (track_full),
        .issue_o         (issue),
        .issue_port_o    (issue_port),
        .lvl             (lvl_if_inst.sched)
    );

    qos_level_bank qos_level_bank_inst (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .port_req_i (port_req),
        .lvl        (lvl_if_inst.bank)
    );

    qos_rsp_router qos_rsp_router_inst (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .issue_i         (issue),
        .issue_port_i    (issue_port),
        .track_full_o    (track_full),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_rdata_i (mem_rsp_rdata_i),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_rdata_o     (rsp_rdata_o),
        .rsp_done_o      (rsp_done),
        .rsp_port_o      (rsp_port)
    );

    qos_port_stats qos_port_stats_inst (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .issue_i      (issue),
        .issue_port_i (issue_port),
        .rsp_done_i   (rsp_done),
        .rsp_port_i   (rsp_port),
        .issued_cnt_o (issued_cnt_o),
        .done_cnt_o   (done_cnt_o)
    );

endmodule

//--- bench/qosmem_chk.sv
// Expects the testbench to publish its expected ready and memory-valid values before each edge
`timescale 1ns/10ps

module qosmem_chk (
    input logic       clk_i,
    input logic       rst_ni,
    input logic [3:0] req_ready_i,
    input logic [3:0] rsp_valid_i,
    input logic       mem_req_valid_i,
    input logic       mem_rsp_valid_i,
    input logic       exp_mem_valid_i,
    input logic [3:0] exp_ready_i
);

    // ------------------------------------------------------------------------
    // Response routing
    // ------------------------------------------------------------------------
    // Every memory response reaches exactly one port one cycle later
    a_rsp_follows: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_rsp_valid_i |=> $onehot(rsp_valid_i))
        else $error("memory response was not routed to exactly one port");

    a_rsp_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !mem_rsp_valid_i |=> (rsp_valid_i == '0))
        else $error("response strobe without a memory response");

    // ------------------------------------------------------------------------
    // Intake and issue against the model
    // ------------------------------------------------------------------------
    a_mem_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_i == exp_mem_valid_i)
        else $error("memory request valid differs from the model");

    a_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_ready_i == exp_ready_i)
        else $error("port ready differs from the intake rule");

endmodule

//--- bench/qosmem_tb.sv
// Checks at 8 ns after each falling edge, before the rising edge; address bits 31:30 hold the port
`timescale 1ns/10ps

module qosmem_tb;

    localparam int NUM_TXN = 200;

    logic                              clk_i = 1'b0;
    logic                              rst_ni;
    logic [3:0]                        req_valid_i;
    logic [3:0][31:0]                  req_addr_i;
    logic [3:0]                        req_we_i;
    logic [3:0][31:0]                  req_wdata_i;
    qosmem_pkg::level_t [3:0]          port_level_i;
    logic [3:0]                        req_ready_o;
    logic [3:0]                        rsp_valid_o;
    logic [3:0][31:0]                  rsp_rdata_o;
    logic                              mem_req_valid_o;
    logic                              mem_req_ready_i;
    logic [31:0]                       mem_req_addr_o;
    logic                              mem_req_we_o;
    logic [31:0]                       mem_req_wdata_o;
    logic                              mem_rsp_valid_i;
    logic [31:0]                       mem_rsp_rdata_i;
    logic [3:0][15:0]                  issued_cnt_o;
    logic [3:0][15:0]                  done_cnt_o;

    // Model state
    int          seed;
    // Level queue entries are {we, wdata, addr}
    logic [64:0] lvl_q [4][$];
    logic [31:0] out_addr [$];
    logic [1:0]  out_port [$];
    int          issued_cnt [4];
    int          done_cnt [4];
    int          seq [4];
    int          accepted;
    int          issued_tot;
    int          exp_rsp_port;
    logic [31:0] exp_rsp_data;
    logic        exp_mem_valid;
    logic [3:0]  exp_ready;

    qosmem_top qosmem_top_inst (.*);

    bind qosmem_top qosmem_chk qosmem_chk_inst (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .req_ready_i     (req_ready_o),
        .rsp_valid_i     (rsp_valid_o),
        .mem_req_valid_i (mem_req_valid_o),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .exp_mem_valid_i (qosmem_tb.exp_mem_valid),
        .exp_ready_i     (qosmem_tb.exp_ready)
    );

    always #10 clk_i = ~clk_i;

    initial begin
        #(NUM_TXN * 50 * 20);
        $display("SOME TESTS FAILED");
        $fatal(1, "Watchdog expired before all traffic drained");
    end

    task automatic report_failure(input string msg);
        $display("SOME TESTS FAILED");
        $display("[ERROR] time %0t: %s", $time, msg);
        $fatal(1, "Check failed");
    endtask

    function automatic bit chance(input int pct);
        int unsigned r;
        r = $random(seed);
        return (r % 100) < pct;
    endfunction

    function automatic bit model_busy();
        bit busy;
        busy = (out_addr.size() != 0) || (exp_rsp_port >= 0);
        for (int l = 0; l < 4; l++) begin
            busy |= (lvl_q[l].size() != 0);
        end
        return busy;
    endfunction

    // ------------------------------------------------------------------------
    // Per-cycle check and model update, just before the rising edge
    // ------------------------------------------------------------------------
    task automatic check_cycle();
        int hi;
        bit blk;
        logic [64:0] head;
        // Results of the previous cycle
        for (int p = 0; p < 4; p++) begin
            assert (rsp_valid_o[p] == (p == exp_rsp_port))
                else report_failure($sformatf("rsp_valid_o[%0d] wrong", p));
            assert (issued_cnt_o[p] == 16'(issued_cnt[p]))
                else report_failure($sformatf("issued_cnt_o[%0d] wrong", p));
            assert (done_cnt_o[p] == 16'(done_cnt[p]))
                else report_failure($sformatf("done_cnt_o[%0d] wrong", p));
        end
        if (exp_rsp_port >= 0) begin
            assert (rsp_rdata_o[exp_rsp_port] == exp_rsp_data)
                else report_failure("response data differs from memory data");
            done_cnt[exp_rsp_port]++;
        end
        // Intake rule, lowest index wins a level
        for (int p = 0; p < 4; p++) begin
            blk = 1'b0;
            for (int q = 0; q < p; q++) begin
                if (req_valid_i[q] && port_level_i[q] == port_level_i[p]) begin
                    blk = 1'b1;
                end
            end
            exp_ready[p] = (lvl_q[port_level_i[p]].size() < 4) && !blk;
        end
        assert (req_ready_o == exp_ready) else report_failure("req_ready_o wrong");
        // Strict priority issue
        hi = -1;
        for (int l = 3; l >= 0; l--) begin
            if (hi < 0 && lvl_q[l].size() != 0) begin
                hi = l;
            end
        end
        exp_mem_valid = (hi >= 0) && (out_addr.size() < 8);
        assert (mem_req_valid_o == exp_mem_valid) else report_failure("mem_req_valid_o wrong");
        if (exp_mem_valid) begin
            assert ({mem_req_we_o, mem_req_wdata_o, mem_req_addr_o} == lvl_q[hi][0])
                else report_failure("issued request is not the oldest of the top level");
            if (mem_req_ready_i) begin
                head = lvl_q[hi].pop_front();
                out_addr.push_back(head[31:0]);
                out_port.push_back(head[31:30]);
                issued_cnt[head[31:30]]++;
                issued_tot++;
            end
        end
        // Memory response, routed next cycle
        exp_rsp_port = -1;
        if (mem_rsp_valid_i) begin
            exp_rsp_port = out_port.pop_front();
            exp_rsp_data = ~out_addr.pop_front();
        end
        for (int p = 0; p < 4; p++) begin
            if (req_valid_i[p] && req_ready_o[p]) begin
                lvl_q[port_level_i[p]].push_back({req_we_i[p], req_wdata_i[p], req_addr_i[p]});
                seq[p]++;
                accepted++;
            end
        end
    endtask

    // Drive on the falling edge, check, then wait for the next falling edge
    task automatic step(input int valid_pct, input int ready_pct, input int rsp_pct);
        for (int p = 0; p < 4; p++) begin
            req_valid_i[p] = chance(valid_pct);
            req_addr_i[p]  = {2'(p), 30'(seq[p])};
            req_we_i[p]    = chance(50);
            req_wdata_i[p] = $random(seed);
        end
        mem_req_ready_i = chance(ready_pct);
        mem_rsp_valid_i = (out_addr.size() != 0) && chance(rsp_pct);
        mem_rsp_rdata_i = mem_rsp_valid_i ? ~out_addr[0] : '0;
        #8;
        check_cycle();
        @(negedge clk_i);
    endtask

    initial begin
        int issued_sum;
        int done_sum;
        seed            = 32'hd00112b9;
        rst_ni          = 1'b0;
        req_valid_i     = '0;
        req_addr_i      = '0;
        req_we_i        = '0;
        req_wdata_i     = '0;
        port_level_i    = '0;
        mem_req_ready_i = 1'b0;
        mem_rsp_valid_i = 1'b0;
        mem_rsp_rdata_i = '0;
        exp_rsp_port    = -1;
        exp_mem_valid   = 1'b0;
        exp_ready       = '0;
        accepted        = 0;
        issued_tot      = 0;
        repeat (3) @(negedge clk_i);
        rst_ni = 1'b1;

        // Fill every level with memory stalled, then issue without answers
        port_level_i = {2'd3, 2'd2, 2'd1, 2'd0};
        repeat (8) step(100, 0, 0);
        repeat (24) step(0, 100, 0);
        while (model_busy()) step(0, 100, 100);

        // Two ports per level to exercise intake conflicts
        port_level_i = {2'd1, 2'd1, 2'd2, 2'd2};
        repeat (NUM_TXN) step(60, 70, 40);
        while (model_busy()) step(0, 100, 100);
        step(0, 0, 0);

        // Every accepted request issued and answered once
        issued_sum = 0;
        done_sum   = 0;
        for (int p = 0; p < 4; p++) begin
            issued_sum += int'(issued_cnt_o[p]);
            done_sum   += int'(done_cnt_o[p]);
        end

        if (accepted > 0 && issued_sum == accepted && done_sum == accepted) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            report_failure("issued or completed totals differ from accepted requests");
        end
    end

endmodule

//--- qosmem_top.f
src/qosmem_pkg.sv
src/qos_level_if.sv
src/qos_fifo.sv
src/qos_level_bank.sv
src/qos_scheduler.sv
src/qos_rsp_router.sv
src/qos_port_stats.sv
src/qosmem_top.sv
bench/qosmem_chk.sv
bench/qosmem_tb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it; a failing run exits non-zero
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
    --top-module qosmem_tb \
    -f qosmem_top.f \
    -o qosmem_sim
./obj_dir/qosmem_sim
